// File: lsu_pkg.sv
package lsu_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;
  // byte position inside a word
  typedef logic [1:0] byte_off_t;

  // memory operations from the execute stage
  typedef enum logic [3:0] {
    MEM_NONE = 4'h0,
    MEM_LB   = 4'h1,
    MEM_LBU  = 4'h2,
    MEM_LH   = 4'h3,
    MEM_LHU  = 4'h4,
    MEM_LW   = 4'h5,
    MEM_SB   = 4'h6,
    MEM_SH   = 4'h7,
    MEM_SW   = 4'h8
  } mem_op_e;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    word_t   wdata;
  } lsu_req_t;

  // load bus request
  typedef struct packed {
    addr_t addr;
    strb_t strb;
  } rd_req_t;

  // store bus request
  typedef struct packed {
    addr_t addr;
    word_t data;
    strb_t strb;
  } wr_req_t;

  // l1d geometry, one word per line
  localparam int unsigned L1D_IDX_W = 1;
  localparam int unsigned L1D_LINES = 1 << L1D_IDX_W;
  localparam int unsigned L1D_TAG_W = ADDR_W - L1D_IDX_W - 2;
  typedef logic [L1D_IDX_W-1:0] l1d_idx_t;
  typedef logic [L1D_TAG_W-1:0] l1d_tag_t;

  // data ram
  localparam int unsigned RAM_WORDS   = 256;
  localparam int unsigned RAM_IDX_W   = $clog2(RAM_WORDS);
  localparam int unsigned RAM_LATENCY = 2;
  localparam int unsigned LAT_W       = $clog2(RAM_LATENCY + 1);
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;
  typedef logic [LAT_W-1:0] lat_cnt_t;

  // cacheable windows, low bound inclusive, high bound exclusive
  localparam addr_t CACHE_WIN0_LO = 32'h3000_0000;
  localparam addr_t CACHE_WIN0_HI = 32'h4000_0000;
  localparam addr_t CACHE_WIN1_LO = 32'h8000_0000;
  localparam addr_t CACHE_WIN1_HI = 32'h8040_0000;
  localparam addr_t CACHE_WIN2_LO = 32'hA000_0000;
  localparam addr_t CACHE_WIN2_HI = 32'hC000_0000;

endpackage

// File: lsu_l1d_cache.sv
`timescale 1ns/10ps

module lsu_l1d_cache (
  input  logic           clk,
  input  logic           rst,

  // load lookup
  input  lsu_pkg::addr_t lkp_addr_i,
  input  logic           lkp_en_i,

  // store lookup, invalidates on match
  input  lsu_pkg::addr_t st_addr_i,
  input  logic           st_en_i,

  // line fill from the load bus
  input  lsu_pkg::word_t fill_data_i,
  input  logic           fill_i,

  output logic           hit_o,
  output lsu_pkg::word_t hit_data_o,
  output logic           cached_fill_o
);
  import lsu_pkg::*;

  word_t              data_q [L1D_LINES];
  l1d_tag_t           tag_q  [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  l1d_idx_t lkp_idx;
  l1d_tag_t lkp_tag;
  l1d_idx_t st_idx;
  l1d_tag_t st_tag;
  logic     lkp_cacheable;
  logic     st_match;

  function automatic logic in_window(addr_t a);
    logic w0;
    logic w1;
    logic w2;
    w0 = (a >= CACHE_WIN0_LO) && (a < CACHE_WIN0_HI);
    w1 = (a >= CACHE_WIN1_LO) && (a < CACHE_WIN1_HI);
    w2 = (a >= CACHE_WIN2_LO) && (a < CACHE_WIN2_HI);
    return w0 | w1 | w2;
  endfunction

  // address split, byte offset dropped
  assign lkp_idx = lkp_addr_i[L1D_IDX_W+1:2];
  assign lkp_tag = lkp_addr_i[ADDR_W-1:L1D_IDX_W+2];
  assign st_idx  = st_addr_i[L1D_IDX_W+1:2];
  assign st_tag  = st_addr_i[ADDR_W-1:L1D_IDX_W+2];

  assign lkp_cacheable = in_window(lkp_addr_i);

  assign hit_o      = lkp_en_i & valid_q[lkp_idx] & (tag_q[lkp_idx] == lkp_tag);
  assign hit_data_o = data_q[lkp_idx];

  // only fills inside a window are kept
  assign cached_fill_o = fill_i & lkp_cacheable;

  assign st_match = st_en_i & valid_q[st_idx] & (tag_q[st_idx] == st_tag);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (cached_fill_o) begin
        valid_q[lkp_idx] <= 1'b1;
      end
      // store hit drops the line, no write-allocate
      if (st_match) begin
        valid_q[st_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cached_fill_o) begin
      data_q[lkp_idx] <= fill_data_i;
      tag_q[lkp_idx]  <= lkp_tag;
    end
  end

endmodule

// File: lsu_load_align.sv
`timescale 1ns/10ps

module lsu_load_align (
  input  lsu_pkg::word_t     raw_i,
  input  lsu_pkg::byte_off_t offset_i,
  input  lsu_pkg::mem_op_e   op_i,
  output lsu_pkg::word_t     data_o
);
  import lsu_pkg::*;

  word_t shifted;

  // bring the addressed byte down to lane 0
  assign shifted = raw_i >> {offset_i, 3'b000};

  always_comb begin
    case (op_i)
      MEM_LB: begin
        data_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      MEM_LBU: begin
        data_o = {24'h0, shifted[7:0]};
      end
      MEM_LH: begin
        data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      MEM_LHU: begin
        data_o = {16'h0, shifted[15:0]};
      end
      MEM_LW: begin
        data_o = shifted;
      end
      // stores and idle return nothing
      default: begin
        data_o = '0;
      end
    endcase
  end

endmodule

// File: lsu_core.sv
`timescale 1ns/10ps

module lsu_core (
  input  logic               clk,
  input  logic               rst,

  // execute stage request
  input  lsu_pkg::lsu_req_t  req_i,
  input  logic               ren_i,
  input  logic               wen_i,
  input  logic               avalid_i,
  output lsu_pkg::word_t     rdata_o,
  output logic               rvalid_o,
  output logic               wready_o,

  // load bus
  output lsu_pkg::rd_req_t   rd_req_o,
  output logic               arvalid_o,
  input  lsu_pkg::word_t     bus_rdata_i,
  input  logic               bus_rvalid_i,

  // store bus
  output lsu_pkg::wr_req_t   wr_req_o,
  output logic               wvalid_o,
  input  logic               bus_wready_i,

  // cache
  output lsu_pkg::addr_t     lkp_addr_o,
  output logic               lkp_en_o,
  output lsu_pkg::addr_t     st_addr_o,
  output logic               st_en_o,
  output lsu_pkg::word_t     fill_data_o,
  output logic               fill_o,
  input  logic               hit_i,
  input  lsu_pkg::word_t     hit_data_i,
  input  logic               cached_fill_i,

  // load aligner
  output lsu_pkg::word_t     raw_o,
  output lsu_pkg::byte_off_t offset_o,
  output lsu_pkg::mem_op_e   op_o,
  input  lsu_pkg::word_t     aligned_i
);
  import lsu_pkg::*;

  byte_off_t offset;
  strb_t     size_strb;
  strb_t     lane_strb;
  word_t     lane_wdata;
  logic      load_act;
  logic      store_act;
  logic      uc_fill;

  // uncached read data and its one-cycle valid
  word_t     rdata_q;
  logic      valid_q;

  assign offset    = req_i.addr[1:0];
  assign load_act  = ren_i & avalid_i;
  assign store_act = wen_i & avalid_i;

  // access width
  always_comb begin
    case (req_i.op)
      MEM_LB, MEM_LBU, MEM_SB: size_strb = 4'h1;
      MEM_LH, MEM_LHU, MEM_SH: size_strb = 4'h3;
      MEM_LW, MEM_SW:          size_strb = 4'hF;
      default:                 size_strb = 4'h0;
    endcase
  end

  assign lane_strb  = size_strb << offset;
  assign lane_wdata = req_i.wdata << {offset, 3'b000};

  always_comb begin
    rd_req_o.addr = req_i.addr;
    rd_req_o.strb = load_act ? lane_strb : '0;
  end

  always_comb begin
    wr_req_o.addr = req_i.addr;
    wr_req_o.data = lane_wdata;
    wr_req_o.strb = store_act ? lane_strb : '0;
  end

  // no bus read on a hit or while the uncached answer is shown
  assign arvalid_o = load_act & ~hit_i & ~valid_q;
  assign wvalid_o  = store_act;
  assign wready_o  = bus_wready_i;

  assign lkp_addr_o  = req_i.addr;
  assign lkp_en_o    = load_act;
  assign st_addr_o   = req_i.addr;
  assign st_en_o     = store_act;
  assign fill_data_o = bus_rdata_i;
  assign fill_o      = load_act & bus_rvalid_i;

  // the cache keeps cacheable fills, the rest lands here
  assign uc_fill = fill_o & ~cached_fill_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= uc_fill;
    end
  end

  always_ff @(posedge clk) begin
    if (uc_fill) begin
      rdata_q <= bus_rdata_i;
    end
  end

  assign raw_o    = valid_q ? rdata_q : hit_data_i;
  assign offset_o = offset;
  assign op_o     = req_i.op;

  assign rdata_o  = aligned_i;
  assign rvalid_o = valid_q | hit_i;

endmodule

// File: lsu_data_ram.sv
`timescale 1ns/10ps

module lsu_data_ram (
  input  logic             clk,
  input  logic             rst,

  // load side
  input  lsu_pkg::rd_req_t rd_req_i,
  input  logic             arvalid_i,
  output lsu_pkg::word_t   rdata_o,
  output logic             rvalid_o,

  // store side
  input  lsu_pkg::wr_req_t wr_req_i,
  input  logic             wvalid_i,
  output logic             wready_o
);
  import lsu_pkg::*;

  word_t    mem [RAM_WORDS];
  ram_idx_t rd_idx;
  ram_idx_t wr_idx;
  lat_cnt_t rd_cnt;
  lat_cnt_t wr_cnt;
  logic     rd_accept;
  logic     wr_accept;

  // low bits only, upper address bits alias
  assign rd_idx = rd_req_i.addr[RAM_IDX_W+1:2];
  assign wr_idx = wr_req_i.addr[RAM_IDX_W+1:2];

  // one outstanding access per side
  assign rd_accept = arvalid_i & (rd_cnt == '0);
  assign wr_accept = wvalid_i & (wr_cnt == '0);

  // counters count down to the response cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (rd_accept) begin
        rd_cnt <= lat_cnt_t'(RAM_LATENCY);
      end else if (rd_cnt != '0) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
      if (wr_accept) begin
        wr_cnt <= lat_cnt_t'(RAM_LATENCY);
      end else if (wr_cnt != '0) begin
        wr_cnt <= wr_cnt - 1'b1;
      end
    end
  end

  assign rvalid_o = (rd_cnt == lat_cnt_t'(1));
  assign wready_o = (wr_cnt == lat_cnt_t'(1));

  // read is captured at accept and held until the pulse
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_o <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_req_i.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_req_i.data[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: lsu_subsys_top.sv
`timescale 1ns/10ps

module lsu_subsys_top (
  input  logic              clk,
  input  logic              rst,

  input  lsu_pkg::lsu_req_t req_i,
  input  logic              ren_i,
  input  logic              wen_i,
  input  logic              avalid_i,
  output lsu_pkg::word_t    rdata_o,
  output logic              rvalid_o,
  output logic              wready_o,

  // monitor copy of the load bus strobe
  output logic              arvalid_o
);
  import lsu_pkg::*;

  rd_req_t   rd_req;
  wr_req_t   wr_req;
  word_t     bus_rdata;
  logic      bus_rvalid;
  logic      wvalid;
  logic      bus_wready;
  addr_t     lkp_addr;
  logic      lkp_en;
  addr_t     st_addr;
  logic      st_en;
  word_t     fill_data;
  logic      fill;
  logic      hit;
  word_t     hit_data;
  logic      cached_fill;
  word_t     raw;
  byte_off_t offset;
  mem_op_e   op;
  word_t     aligned;

  lsu_core lsu_core_i (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .ren_i         (ren_i),
    .wen_i         (wen_i),
    .avalid_i      (avalid_i),
    .rdata_o       (rdata_o),
    .rvalid_o      (rvalid_o),
    .wready_o      (wready_o),
    .rd_req_o      (rd_req),
    .arvalid_o     (arvalid_o),
    .bus_rdata_i   (bus_rdata),
    .bus_rvalid_i  (bus_rvalid),
    .wr_req_o      (wr_req),
    .wvalid_o      (wvalid),
    .bus_wready_i  (bus_wready),
    .lkp_addr_o    (lkp_addr),
    .lkp_en_o      (lkp_en),
    .st_addr_o     (st_addr),
    .st_en_o       (st_en),
    .fill_data_o   (fill_data),
    .fill_o        (fill),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .cached_fill_i (cached_fill),
    .raw_o         (raw),
    .offset_o      (offset),
    .op_o          (op),
    .aligned_i     (aligned)
  );

  lsu_l1d_cache lsu_l1d_cache_i (
    .clk           (clk),
    .rst           (rst),
    .lkp_addr_i    (lkp_addr),
    .lkp_en_i      (lkp_en),
    .st_addr_i     (st_addr),
    .st_en_i       (st_en),
    .fill_data_i   (fill_data),
    .fill_i        (fill),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .cached_fill_o (cached_fill)
  );

  lsu_load_align lsu_load_align_i (
    .raw_i    (raw),
    .offset_i (offset),
    .op_i     (op),
    .data_o   (aligned)
  );

  lsu_data_ram lsu_data_ram_i (
    .clk      (clk),
    .rst      (rst),
    .rd_req_i (rd_req),
    .arvalid_i(arvalid_o),
    .rdata_o  (bus_rdata),
    .rvalid_o (bus_rvalid),
    .wr_req_i (wr_req),
    .wvalid_i (wvalid),
    .wready_o (bus_wready)
  );

endmodule

// File: tb_lsu_subsys.sv
`timescale 1ns/10ps

module tb_lsu_subsys;
  import lsu_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 20;
  localparam int unsigned RAND_GROUPS    = 8;

  // three cacheable words and two uncached ones on distinct ram words
  localparam addr_t ADDR_A = 32'h3000_0010;
  localparam addr_t ADDR_B = 32'h8000_0014;
  localparam addr_t ADDR_C = 32'hA000_0020;
  localparam addr_t ADDR_U = 32'h0000_0100;
  localparam addr_t ADDR_V = 32'h0000_0104;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    word_t   wdata;
    word_t   exp_data;
    logic    exp_hit;
  } entry_t;

  logic     clk;
  logic     rst;
  lsu_req_t req_i;
  logic     ren_i;
  logic     wen_i;
  logic     avalid_i;
  word_t    rdata_o;
  logic     rvalid_o;
  logic     wready_o;
  logic     arvalid_o;

  entry_t     tbl [$];
  logic [7:0] ref_mem [RAM_WORDS*4];
  int         err_cnt;
  int         check_cnt;
  int         timeout_cnt;

  lsu_subsys_top lsu_subsys_top_i (
    .clk       (clk),
    .rst       (rst),
    .req_i     (req_i),
    .ren_i     (ren_i),
    .wen_i     (wen_i),
    .avalid_i  (avalid_i),
    .rdata_o   (rdata_o),
    .rvalid_o  (rvalid_o),
    .wready_o  (wready_o),
    .arvalid_o (arvalid_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic is_load_op(mem_op_e op);
    case (op)
      MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void add_entry(mem_op_e op, addr_t addr, word_t wdata, logic exp_hit);
    entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_data = '0;
    e.exp_hit  = exp_hit;
    tbl.push_back(e);
  endfunction

  // reference bytes indexed by address bits [9:2] and the lane like the ram
  function automatic void store_to_model(mem_op_e op, addr_t addr, word_t wdata);
    int base;
    base = int'(addr[9:2]) * 4 + int'(addr[1:0]);
    case (op)
      MEM_SB: begin
        ref_mem[base] = wdata[7:0];
      end
      MEM_SH: begin
        ref_mem[base]     = wdata[7:0];
        ref_mem[base + 1] = wdata[15:8];
      end
      MEM_SW: begin
        for (int i = 0; i < 4; i++) begin
          ref_mem[base + i] = wdata[8*i +: 8];
        end
      end
      default: begin
      end
    endcase
  endfunction

  function automatic word_t expected_load(mem_op_e op, addr_t addr);
    int          base;
    logic [15:0] half;
    base = int'(addr[9:2]) * 4 + int'(addr[1:0]);
    case (op)
      MEM_LB:  return {{24{ref_mem[base][7]}}, ref_mem[base]};
      MEM_LBU: return {24'h0, ref_mem[base]};
      MEM_LH: begin
        half = {ref_mem[base + 1], ref_mem[base]};
        return {{16{half[15]}}, half};
      end
      MEM_LHU: begin
        half = {ref_mem[base + 1], ref_mem[base]};
        return {16'h0, half};
      end
      default: return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endcase
  endfunction

  function automatic void add_directed_entries();
    // cacheable word store and load and then a repeat hit
    add_entry(MEM_SW,  ADDR_A,     32'h1234_5678, 1'b0);
    add_entry(MEM_LW,  ADDR_A,     '0,            1'b0);
    add_entry(MEM_LW,  ADDR_A,     '0,            1'b1);
    // uncached word never hits
    add_entry(MEM_SW,  ADDR_U,     32'hCAFE_F00D, 1'b0);
    add_entry(MEM_LW,  ADDR_U,     '0,            1'b0);
    add_entry(MEM_LW,  ADDR_U,     '0,            1'b0);
    // store hit drops the line
    add_entry(MEM_SB,  ADDR_A + 1, 32'h0000_00A5, 1'b0);
    add_entry(MEM_LW,  ADDR_A,     '0,            1'b0);
    add_entry(MEM_LBU, ADDR_A + 1, '0,            1'b1);
    add_entry(MEM_LB,  ADDR_A + 1, '0,            1'b1);
    // A and C share index 0
    add_entry(MEM_SW,  ADDR_C,     32'h0BAD_BEEF, 1'b0);
    add_entry(MEM_LW,  ADDR_C,     '0,            1'b0);
    add_entry(MEM_LW,  ADDR_A,     '0,            1'b0);
    add_entry(MEM_LW,  ADDR_C,     '0,            1'b0);
    // byte lanes on an uncached word
    add_entry(MEM_SW,  ADDR_V,     32'h1122_3344, 1'b0);
    add_entry(MEM_SB,  ADDR_V,     32'h0000_0080, 1'b0);
    add_entry(MEM_SB,  ADDR_V + 3, 32'h0000_00F3, 1'b0);
    add_entry(MEM_LW,  ADDR_V,     '0,            1'b0);
    add_entry(MEM_LB,  ADDR_V,     '0,            1'b0);
    add_entry(MEM_LBU, ADDR_V,     '0,            1'b0);
    add_entry(MEM_LB,  ADDR_V + 1, '0,            1'b0);
    add_entry(MEM_LBU, ADDR_V + 3, '0,            1'b0);
    add_entry(MEM_SB,  ADDR_V + 1, 32'h0000_00C1, 1'b0);
    add_entry(MEM_SB,  ADDR_V + 2, 32'h0000_0002, 1'b0);
    add_entry(MEM_LW,  ADDR_V,     '0,            1'b0);
    // halfword lanes
    add_entry(MEM_SH,  ADDR_V,     32'h0000_8001, 1'b0);
    add_entry(MEM_SH,  ADDR_V + 2, 32'h0000_7FFE, 1'b0);
    add_entry(MEM_LH,  ADDR_V,     '0,            1'b0);
    add_entry(MEM_LHU, ADDR_V,     '0,            1'b0);
    add_entry(MEM_LH,  ADDR_V + 2, '0,            1'b0);
    add_entry(MEM_LHU, ADDR_V + 2, '0,            1'b0);
    add_entry(MEM_LW,  ADDR_V,     '0,            1'b0);
    // narrow loads from a cached line on index 1
    add_entry(MEM_SW,  ADDR_B,     32'hDEAD_BEEF, 1'b0);
    add_entry(MEM_LH,  ADDR_B + 2, '0,            1'b0);
    add_entry(MEM_LHU, ADDR_B + 2, '0,            1'b1);
    add_entry(MEM_LB,  ADDR_B,     '0,            1'b1);
    add_entry(MEM_SH,  ADDR_B,     32'h0000_1357, 1'b0);
    add_entry(MEM_LW,  ADDR_B,     '0,            1'b0);
    add_entry(MEM_LBU, ADDR_B + 3, '0,            1'b1);
  endfunction

  // uncached aliases in ram words 0x80 to 0xff
  function automatic void add_random_groups(int groups);
    logic [9:0] low;
    addr_t      st_addr;
    addr_t      ld_addr;
    for (int g = 0; g < groups; g++) begin
      low     = 10'h200 + 10'($urandom_range(0, 127) * 4);
      st_addr = {4'($urandom_range(0, 2)), 18'($urandom), low};
      ld_addr = {4'($urandom_range(0, 2)), 18'($urandom), low};
      add_entry(MEM_SW, st_addr, $urandom, 1'b0);
      if ($urandom_range(0, 1) == 0) begin
        add_entry(MEM_SB, st_addr + $urandom_range(0, 3), $urandom, 1'b0);
      end else begin
        add_entry(MEM_SH, st_addr + 2 * $urandom_range(0, 1), $urandom, 1'b0);
      end
      case ($urandom_range(0, 4))
        0: add_entry(MEM_LB, ld_addr + $urandom_range(0, 3), '0, 1'b0);
        1: add_entry(MEM_LBU, ld_addr + $urandom_range(0, 3), '0, 1'b0);
        2: add_entry(MEM_LH, ld_addr + 2 * $urandom_range(0, 1), '0, 1'b0);
        3: add_entry(MEM_LHU, ld_addr + 2 * $urandom_range(0, 1), '0, 1'b0);
        default: add_entry(MEM_LW, ld_addr, '0, 1'b0);
      endcase
    end
  endfunction

  task automatic run_access(input int idx);
    entry_t  e;
    mem_op_e op;
    logic    load;
    logic    done;
    logic    saw_ar;
    int      cycles;
    e      = tbl[idx];
    op     = e.op;
    load   = is_load_op(op);
    done   = 1'b0;
    saw_ar = 1'b0;
    cycles = 0;
    @(posedge clk);
    req_i.op    <= e.op;
    req_i.addr  <= e.addr;
    req_i.wdata <= e.wdata;
    ren_i       <= load;
    wen_i       <= ~load;
    avalid_i    <= 1'b1;
    // outputs are sampled half a period after the drive edge
    while (!done && cycles <= TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (arvalid_o) begin
        saw_ar = 1'b1;
      end
      if (load ? rvalid_o : wready_o) begin
        done = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!done) begin
      $display("entry %0d, %s at %h, never completed", idx, op.name(), e.addr);
      timeout_cnt++;
    end else if (load) begin
      check_cnt++;
      if (rdata_o !== e.exp_data) begin
        $display("ERR %0t entry %0d %s at %h returned %h, expected %h",
                 $time, idx, op.name(), e.addr, rdata_o, e.exp_data);
        err_cnt++;
      end
      if (e.exp_hit && (cycles != 0 || saw_ar)) begin
        $display("ERR %0t entry %0d expected a hit, took %0d cycles, arvalid %b",
                 $time, idx, cycles, saw_ar);
        err_cnt++;
      end
      if (!e.exp_hit && (cycles != RAM_LATENCY + 1 || !saw_ar)) begin
        $display("ERR %0t entry %0d expected a miss, took %0d cycles, arvalid %b",
                 $time, idx, cycles, saw_ar);
        err_cnt++;
      end
    end else begin
      check_cnt++;
      if (cycles != RAM_LATENCY) begin
        $display("ERR %0t entry %0d store took %0d cycles", $time, idx, cycles);
        err_cnt++;
      end
    end
    @(posedge clk);
    avalid_i <= 1'b0;
    ren_i    <= 1'b0;
    wen_i    <= 1'b0;
    req_i.op <= MEM_NONE;
    // response must be a single cycle
    @(negedge clk);
    if (done && (rvalid_o || wready_o)) begin
      $display("ERR %0t entry %0d response held past one cycle", $time, idx);
      err_cnt++;
    end
  endtask

  initial begin
    void'($urandom(32'hfa06));
    err_cnt     = 0;
    check_cnt   = 0;
    timeout_cnt = 0;
    rst         = 1'b1;
    req_i       = '0;
    ren_i       = 1'b0;
    wen_i       = 1'b0;
    avalid_i    = 1'b0;
    add_directed_entries();
    add_random_groups(RAND_GROUPS);
    // expected load values follow the table order
    foreach (tbl[i]) begin
      if (is_load_op(tbl[i].op)) begin
        tbl[i].exp_data = expected_load(tbl[i].op, tbl[i].addr);
      end else begin
        store_to_model(tbl[i].op, tbl[i].addr, tbl[i].wdata);
      end
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if ((arvalid_o !== 1'b0) || (rvalid_o !== 1'b0) || (wready_o !== 1'b0)) begin
      $display("ERR %0t outputs not low after reset", $time);
      err_cnt++;
    end
    for (int i = 0; i < tbl.size() && timeout_cnt == 0; i++) begin
      run_access(i);
    end
    $display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
lsu_pkg.sv
lsu_l1d_cache.sv
lsu_load_align.sv
lsu_core.sv
lsu_data_ram.sv
lsu_subsys_top.sv
tb_lsu_subsys.sv

// File: Bender.yml
package:
  name: lsu_subsys

sources:
  # package first, then leaf modules, then the top level
  - lsu_pkg.sv
  - lsu_l1d_cache.sv
  - lsu_load_align.sv
  - lsu_core.sv
  - lsu_data_ram.sv
  - lsu_subsys_top.sv

  # testbench, top module tb_lsu_subsys
  - target: test
    files:
      - tb_lsu_subsys.sv
